// File: src/audio_defines.svh
`ifndef AUDIO_DEFINES_SVH
`define AUDIO_DEFINES_SVH

// system clock and serial link
`define AUDIO_CLK_FREQ 12_000_000
`define AUDIO_BAUD 750_000
`define AUDIO_BIT_CYCLES (`AUDIO_CLK_FREQ / `AUDIO_BAUD)

// playback rate, one tick per sample
`define AUDIO_SAMPLE_RATE 11_025
`define AUDIO_SAMPLE_CYCLES (`AUDIO_CLK_FREQ / `AUDIO_SAMPLE_RATE)

// sample buffer size and level marks
`define AUDIO_FIFO_DEPTH 64
`define AUDIO_FILL_BITS ($clog2(`AUDIO_FIFO_DEPTH) + 1)
`define AUDIO_LOW_MARK (`AUDIO_FIFO_DEPTH / 10)
`define AUDIO_HIGH_MARK (`AUDIO_FIFO_DEPTH - 2 * (`AUDIO_FIFO_DEPTH / 10))

`endif

// File: src/audio_pkg.sv
package audio_pkg;

	// one unsigned audio sample
	typedef logic [7:0] sample_t;

	// serial receiver states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

// File: src/uart_receiver.sv
`include "audio_defines.svh"

module uart_receiver (
	input  logic               CLK_IN,
	input  logic               reset_i,
	input  logic               rx_i,
	output audio_pkg::sample_t byte_o,
	output logic               byte_valid_o
);

	localparam int BIT_CYCLES = `AUDIO_BIT_CYCLES;
	localparam int HALF_CYCLES = BIT_CYCLES / 2;
	localparam int CNT_W = $clog2(BIT_CYCLES);

	audio_pkg::rx_state_t state;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic rx_meta;
	logic rx_sync;
	audio_pkg::sample_t shift_q;

	// two-flop synchronizer, line idles high
	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			state <= audio_pkg::RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			byte_valid_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			case (state)
				audio_pkg::RX_IDLE: begin
					if (!rx_sync) begin
						state <= audio_pkg::RX_START;
						cnt <= CNT_W'(HALF_CYCLES - 1);
					end
				end
				audio_pkg::RX_START: begin
					if (cnt != 0) begin
						cnt <= cnt - 1'b1;
					end else if (!rx_sync) begin
						// start bit still low at its centre
						state <= audio_pkg::RX_DATA;
						cnt <= CNT_W'(BIT_CYCLES - 1);
						bit_idx <= '0;
					end else begin
						// glitch, not a start bit
						state <= audio_pkg::RX_IDLE;
					end
				end
				audio_pkg::RX_DATA: begin
					if (cnt != 0) begin
						cnt <= cnt - 1'b1;
					end else begin
						cnt <= CNT_W'(BIT_CYCLES - 1);
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= audio_pkg::RX_STOP;
					end
				end
				audio_pkg::RX_STOP: begin
					if (cnt != 0) begin
						cnt <= cnt - 1'b1;
					end else begin
						// framing error drops the byte
						byte_valid_o <= rx_sync;
						state <= audio_pkg::RX_IDLE;
					end
				end
				default: state <= audio_pkg::RX_IDLE;
			endcase
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge CLK_IN) begin
		if (state == audio_pkg::RX_DATA && cnt == 0)
			shift_q <= {rx_sync, shift_q[7:1]};
	end

	assign byte_o = shift_q;

	a_single_strobe: assert property (@(posedge CLK_IN) disable iff (reset_i)
		byte_valid_o |=> !byte_valid_o);

endmodule

// File: src/sample_fifo.sv
`include "audio_defines.svh"

module sample_fifo #(
	parameter int DEPTH = `AUDIO_FIFO_DEPTH
) (
	input  logic                        CLK_IN,
	input  logic                        reset_i,
	input  logic                        wr_en_i,
	input  audio_pkg::sample_t          wr_data_i,
	input  logic                        rd_en_i,
	output audio_pkg::sample_t          rd_data_o,
	output logic [`AUDIO_FILL_BITS-1:0] fill_o,
	output logic                        empty_o,
	output logic                        full_o
);

	localparam int AW = $clog2(DEPTH);
	localparam int FW = `AUDIO_FILL_BITS;

	audio_pkg::sample_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [FW-1:0] fill_next;
	logic do_wr;
	logic do_rd;

	// full drops writes, empty drops reads
	assign do_wr = wr_en_i && !full_o;
	assign do_rd = rd_en_i && !empty_o;

	always_comb begin
		fill_next = fill_o;
		if (do_wr && !do_rd)
			fill_next = fill_o + 1'b1;
		else if (do_rd && !do_wr)
			fill_next = fill_o - 1'b1;
	end

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill_o <= '0;
			empty_o <= 1'b1;
			full_o <= 1'b0;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			fill_o <= fill_next;
			empty_o <= (fill_next == '0);
			full_o <= (fill_next == FW'(DEPTH));
		end
	end

	always_ff @(posedge CLK_IN) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data_i;
	end

	// head entry, seen before the read
	assign rd_data_o = mem[rd_ptr];

	a_fill_bound: assert property (@(posedge CLK_IN) disable iff (reset_i)
		fill_o <= FW'(DEPTH));

	a_flags_exclusive: assert property (@(posedge CLK_IN) disable iff (reset_i)
		!(empty_o && full_o));

endmodule

// File: src/playback_control.sv
`include "audio_defines.svh"

module playback_control (
	input  logic                        CLK_IN,
	input  logic                        reset_i,
	input  audio_pkg::sample_t          byte_i,
	input  logic                        byte_valid_i,
	input  logic [`AUDIO_FILL_BITS-1:0] fill_i,
	output logic                        wr_en_o,
	output audio_pkg::sample_t          wr_data_o,
	output logic                        rd_en_o,
	output logic                        almost_empty_o,
	output logic                        almost_full_o,
	output logic                        cts_o,
	output logic                        dsr_o
);

	localparam int SAMPLE_CYCLES = `AUDIO_SAMPLE_CYCLES;
	localparam int TW = $clog2(SAMPLE_CYCLES);
	localparam int FW = `AUDIO_FILL_BITS;

	logic [TW-1:0] tick_cnt;

	// sample-rate divider, one tick per period
	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			tick_cnt <= TW'(SAMPLE_CYCLES - 1);
			rd_en_o <= 1'b0;
		end else if (tick_cnt == '0) begin
			tick_cnt <= TW'(SAMPLE_CYCLES - 1);
			rd_en_o <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt - 1'b1;
			rd_en_o <= 1'b0;
		end
	end

	// received byte becomes a fifo write one cycle later
	always_ff @(posedge CLK_IN) begin
		if (reset_i)
			wr_en_o <= 1'b0;
		else
			wr_en_o <= byte_valid_i;
	end

	always_ff @(posedge CLK_IN) begin
		if (byte_valid_i)
			wr_data_o <= byte_i;
	end

	// level marks and flow control to the sender
	assign almost_empty_o = (fill_i <= FW'(`AUDIO_LOW_MARK));
	assign almost_full_o = (fill_i >= FW'(`AUDIO_HIGH_MARK));
	assign cts_o = ~almost_empty_o;
	assign dsr_o = ~almost_full_o;

	a_tick_single: assert property (@(posedge CLK_IN) disable iff (reset_i)
		rd_en_o |=> !rd_en_o);

endmodule

// File: src/sigma_delta_dac.sv
module sigma_delta_dac (
	input  logic               CLK_IN,
	input  logic               reset_i,
	input  logic               tick_i,
	input  logic               empty_i,
	input  audio_pkg::sample_t sample_i,
	output logic               audio_o
);

	audio_pkg::sample_t sample_q;
	logic [7:0] acc;
	logic [8:0] sum;

	// carry out of the accumulator is the pulse density
	assign sum = {1'b0, acc} + {1'b0, sample_q};

	// held sample, taken from the fifo head on a tick
	always_ff @(posedge CLK_IN) begin
		if (empty_i)
			sample_q <= '0;
		else if (tick_i)
			sample_q <= sample_i;
	end

	always_ff @(posedge CLK_IN) begin
		if (reset_i) begin
			acc <= '0;
			audio_o <= 1'b0;
		end else if (empty_i) begin
			// silence while nothing is buffered
			acc <= '0;
			audio_o <= 1'b0;
		end else begin
			acc <= sum[7:0];
			audio_o <= sum[8];
		end
	end

endmodule

// File: src/audio_dac_board.sv
`include "audio_defines.svh"

module audio_dac_board (
	input  logic                        CLK_IN,
	input  logic                        reset_i,
	input  logic                        uart_rx_i,
	output logic                        audio_o,
	output logic                        cts_o,
	output logic                        dsr_o,
	output logic                        empty_o,
	output logic                        full_o,
	output logic                        almost_empty_o,
	output logic                        almost_full_o,
	output logic [`AUDIO_FILL_BITS-1:0] fill_o
);

	audio_pkg::sample_t rx_byte;
	logic rx_valid;
	audio_pkg::sample_t wr_data;
	logic wr_en;
	logic rd_en;
	audio_pkg::sample_t rd_data;

	uart_receiver u_uart_receiver (
		.CLK_IN       (CLK_IN),
		.reset_i      (reset_i),
		.rx_i         (uart_rx_i),
		.byte_o       (rx_byte),
		.byte_valid_o (rx_valid)
	);

	playback_control u_playback_control (
		.CLK_IN         (CLK_IN),
		.reset_i        (reset_i),
		.byte_i         (rx_byte),
		.byte_valid_i   (rx_valid),
		.fill_i         (fill_o),
		.wr_en_o        (wr_en),
		.wr_data_o      (wr_data),
		.rd_en_o        (rd_en),
		.almost_empty_o (almost_empty_o),
		.almost_full_o  (almost_full_o),
		.cts_o          (cts_o),
		.dsr_o          (dsr_o)
	);

	sample_fifo #(.DEPTH(`AUDIO_FIFO_DEPTH)) u_sample_fifo (
		.CLK_IN    (CLK_IN),
		.reset_i   (reset_i),
		.wr_en_i   (wr_en),
		.wr_data_i (wr_data),
		.rd_en_i   (rd_en),
		.rd_data_o (rd_data),
		.fill_o    (fill_o),
		.empty_o   (empty_o),
		.full_o    (full_o)
	);

	// tick doubles as the fifo read strobe
	sigma_delta_dac u_sigma_delta_dac (
		.CLK_IN   (CLK_IN),
		.reset_i  (reset_i),
		.tick_i   (rd_en),
		.empty_i  (empty_o),
		.sample_i (rd_data),
		.audio_o  (audio_o)
	);

endmodule

// File: tb/tb_audio_dac_board.sv
`include "audio_defines.svh"

module tb_audio_dac_board;

	localparam int BIT = `AUDIO_BIT_CYCLES;
	localparam int BYTE_CYCLES = 10 * BIT;
	localparam int SAMPLE_CYCLES = `AUDIO_SAMPLE_CYCLES;
	localparam int DEPTH = `AUDIO_FIFO_DEPTH;
	localparam int FW = `AUDIO_FILL_BITS;
	// next edge, synchronizer, stop-bit centre, then registered write
	localparam int WRITE_DELAY = 1 + 2 + 9 * BIT + BIT / 2 + 2;
	localparam int BURST_BYTES = 90;
	localparam int PWM_BYTES = 4;
	localparam int RUN_CYCLES = (BURST_BYTES + 8) * BYTE_CYCLES
		+ (DEPTH + 3) * SAMPLE_CYCLES + 1000;

	logic CLK_IN;
	logic reset_i;
	logic uart_rx_i;
	logic audio_o;
	logic cts_o;
	logic dsr_o;
	logic empty_o;
	logic full_o;
	logic almost_empty_o;
	logic almost_full_o;
	logic [FW-1:0] fill_o;

	// reference model state
	int cyc;
	int model_cycle;
	logic model_wr;
	logic model_rd;
	logic [FW-1:0] exp_fill;
	int pending_writes[$];
	logic saw_full;

	// pulse density window
	logic [7:0] pwm_value;
	logic pwm_armed;
	logic win_active;
	logic win_done;
	int win_start;
	logic [8:0] high_count;

	logic [31:0] rng_state;

	audio_dac_board u_audio_dac_board (
		.CLK_IN         (CLK_IN),
		.reset_i        (reset_i),
		.uart_rx_i      (uart_rx_i),
		.audio_o        (audio_o),
		.cts_o          (cts_o),
		.dsr_o          (dsr_o),
		.empty_o        (empty_o),
		.full_o         (full_o),
		.almost_empty_o (almost_empty_o),
		.almost_full_o  (almost_full_o),
		.fill_o         (fill_o)
	);

	always #5 CLK_IN = ~CLK_IN;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] next_sample();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic stop_on_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// 8N1 frame sent between falling edges
	task automatic send_byte(input logic [7:0] data, input logic stop_level);
		int i;
		uart_rx_i = 1'b0;
		if (stop_level)
			pending_writes.push_back(cyc + WRITE_DELAY);
		repeat (BIT) @(negedge CLK_IN);
		for (i = 0; i < 8; i++) begin
			uart_rx_i = data[i];
			repeat (BIT) @(negedge CLK_IN);
		end
		uart_rx_i = stop_level;
		repeat (BIT) @(negedge CLK_IN);
	endtask

	task automatic idle_line(input int cycles);
		uart_rx_i = 1'b1;
		repeat (cycles) @(negedge CLK_IN);
	endtask

	// expected fill from stop-bit centres and the tick count
	always @(posedge CLK_IN) begin
		if (reset_i) begin
			cyc <= 0;
			exp_fill <= '0;
			saw_full <= 1'b0;
			win_active <= 1'b0;
			win_done <= 1'b0;
			win_start <= 0;
			high_count <= '0;
		end else begin
			model_cycle = cyc + 1;
			model_wr = 1'b0;
			if (pending_writes.size() > 0 && pending_writes[0] == model_cycle) begin
				void'(pending_writes.pop_front());
				model_wr = (exp_fill != FW'(DEPTH));
			end
			model_rd = (model_cycle > 1) && ((model_cycle - 1) % SAMPLE_CYCLES == 0)
				&& (exp_fill != '0);
			if (model_wr && !model_rd)
				exp_fill <= exp_fill + FW'(1);
			else if (model_rd && !model_wr)
				exp_fill <= exp_fill - FW'(1);
			cyc <= model_cycle;
			if (full_o)
				saw_full <= 1'b1;
			// window opens on the output set one clock after the sample load
			if (model_rd && pwm_armed && !win_active && !win_done) begin
				win_active <= 1'b1;
				win_start <= model_cycle + 2;
				high_count <= '0;
			end else if (win_active && model_cycle >= win_start) begin
				high_count <= high_count + 9'(audio_o);
				if (model_cycle == win_start + 255) begin
					win_active <= 1'b0;
					win_done <= 1'b1;
				end
			end
		end
	end

	a_reset_state: assert property (@(posedge CLK_IN) $fell(reset_i) |->
		empty_o && almost_empty_o && !full_o && !almost_full_o
		&& fill_o == '0 && !cts_o && dsr_o)
		else stop_on_error("outputs differ from the reset state");

	a_fill_model: assert property (@(posedge CLK_IN) disable iff (reset_i)
		fill_o == exp_fill)
		else stop_on_error($sformatf("fill_o is %0d, expected %0d",
			$sampled(fill_o), $sampled(exp_fill)));

	a_empty_full: assert property (@(posedge CLK_IN) disable iff (reset_i)
		empty_o == (fill_o == '0) && full_o == (fill_o == FW'(DEPTH)))
		else stop_on_error($sformatf("empty_o or full_o wrong at fill %0d",
			$sampled(fill_o)));

	a_marks: assert property (@(posedge CLK_IN) disable iff (reset_i)
		almost_empty_o == (fill_o <= FW'(`AUDIO_LOW_MARK))
		&& almost_full_o == (fill_o >= FW'(`AUDIO_HIGH_MARK))
		&& cts_o == (fill_o > FW'(`AUDIO_LOW_MARK))
		&& dsr_o == (fill_o < FW'(`AUDIO_HIGH_MARK)))
		else stop_on_error($sformatf("level or flow flags wrong at fill %0d",
			$sampled(fill_o)));

	a_silent_when_empty: assert property (@(posedge CLK_IN) disable iff (reset_i)
		empty_o |=> !audio_o)
		else stop_on_error("audio_o high while the FIFO is empty");

	a_density: assert property (@(posedge CLK_IN) disable iff (reset_i)
		win_done |-> high_count == 9'(pwm_value))
		else stop_on_error($sformatf("audio_o high %0d times in 256, expected %0d",
			$sampled(high_count), $sampled(pwm_value)));

	initial begin
		#(RUN_CYCLES * 10);
		$display("Timeout: the run did not finish within %0d clock cycles", RUN_CYCLES);
		$display("Test FAILED");
		$fatal(1);
	end

	initial begin
		CLK_IN = 1'b0;
		reset_i = 1'b1;
		uart_rx_i = 1'b1;
		pwm_armed = 1'b0;
		pwm_value = '0;
		rng_state = 32'hfa02;
		repeat (3) @(posedge CLK_IN);
		@(negedge CLK_IN);
		reset_i = 1'b0;
		repeat (20) @(negedge CLK_IN);

		// a few samples, then a frame with a bad stop bit
		repeat (3) send_byte(next_sample(), 1'b1);
		send_byte(next_sample(), 1'b0);
		idle_line(2 * BIT);

		// back to back burst that runs into full and drops bytes
		repeat (BURST_BYTES) send_byte(next_sample(), 1'b1);

		// drain, then refill with a single value
		while (!empty_o) @(negedge CLK_IN);
		pwm_value = next_sample();
		repeat (PWM_BYTES) send_byte(pwm_value, 1'b1);
		pwm_armed = 1'b1;
		while (!win_done) @(negedge CLK_IN);
		repeat (4) @(negedge CLK_IN);

		if (!saw_full) begin
			$display("The FIFO never reported full during the burst");
			$display("Test FAILED");
			$fatal(1);
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: build.f
+incdir+src
src/audio_pkg.sv
src/uart_receiver.sv
src/sample_fifo.sv
src/playback_control.sv
src/sigma_delta_dac.sv
src/audio_dac_board.sv
tb/tb_audio_dac_board.sv

// File: Makefile
TOP := tb_audio_dac_board
SRCS := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
obj_dir/V$(TOP): build.f $(SRCS) $(wildcard src/*.svh)
	verilator --binary --assert -Wno-fatal -f build.f --top-module $(TOP)

# pass only when the pass message shows up in the output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir
